// ==== verif/mem_stimulus.txt ====
// opcode tag addr strb wdata expected_status expected_rdata, all hex
// opcode 0 read, 1 write, 2 and 3 reserved; status 0 ok, 1 error
1 0 010 f deadbeef 0 00000000
0 1 010 0 00000000 0 deadbeef
2 2 010 f 11111111 1 00000000
0 3 010 0 00000000 0 deadbeef
1 4 020 f 01234567 0 00000000
0 5 020 0 00000000 0 01234567
1 6 020 1 aabbccdd 0 00000000
0 7 020 0 00000000 0 012345dd
1 8 020 4 99887766 0 00000000
0 9 020 0 00000000 0 018845dd
1 a 020 a ffeeddcc 0 00000000
0 b 020 0 00000000 0 ff88dddd
3 c 020 f 00000000 1 00000000
0 d 020 0 00000000 0 ff88dddd
1 e 3ff f cafef00d 0 00000000
1 f 000 f 5a5a5a5a 0 00000000
0 0 3ff 0 00000000 0 cafef00d
0 1 000 0 00000000 0 5a5a5a5a
1 2 000 c 12345678 0 00000000
1 3 000 3 9abcdef0 0 00000000
0 4 000 0 00000000 0 1234def0
1 5 3ff 0 ffffffff 0 00000000
0 6 3ff f ffffffff 0 cafef00d
2 7 3ff f 00000000 1 00000000
1 8 155 f 0badc0de 0 00000000
1 9 2aa f 600dcafe 0 00000000
0 a 155 0 00000000 0 0badc0de
0 b 2aa 0 00000000 0 600dcafe
1 c 155 2 00007700 0 00000000
1 d 2aa 8 44000000 0 00000000
0 e 155 0 00000000 0 0bad77de
0 f 2aa 0 00000000 0 440dcafe
3 0 155 0 00000000 1 00000000
0 1 3ff 0 00000000 0 cafef00d
0 2 010 0 00000000 0 deadbeef

// ==== all.f ====
hw/mem_cfg_pkg.sv
hw/mem_cmd_pkg.sv
hw/byte_mem.sv
hw/ram.sv
hw/cmd_decode.sv
hw/cmd_execute.sv
hw/resp_return.sv
hw/mem_subsys_top.sv
verif/mem_subsys_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mem_subsys_tb \
   -o mem_subsys_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/mem_subsys_sim > sim.log 2>&1 || echo "simulator exited with an error status" >> sim.log
cat sim.log
grep -q "Done: errors found" sim.log && { echo "FAIL"; exit 1; }
grep -q "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== verif/mem_subsys_tb.sv ====
module mem_subsys_tb import mem_cfg_pkg::*; import mem_cmd_pkg::*; ();

   localparam int addr_w          = 10;
   localparam int cmd_depth       = 4;
   localparam int resp_depth      = 4;
   localparam int max_lines       = 64;
   localparam int fields          = 7;
   localparam int iso_lines       = 6;  // sent one at a time, latency checked.
   localparam int cycles_per_line = 40;

   typedef struct packed {
      logic [tag_w-1:0]  tag;
      status_e           status;
      logic [data_w-1:0] rdata;
      logic              timed;
      logic [31:0]       accept_cyc;
   } expect_t;

   logic      clk;
   logic      rst;
   logic      cmd_valid;
   cmd_word_t cmd;
   logic      cmd_credit;
   logic      resp_valid;
   resp_t     resp;
   logic      resp_credit;

   logic [31:0] stim [max_lines * fields];
   expect_t     scoreboard [$];
   logic [31:0] lcg_state;
   int          n_lines;
   int          errors;
   int          checks;
   int          cyc = 0;
   bit          loaded = 1'b0;

   mem_subsys_top #(
      .addr_w     (addr_w),
      .cmd_depth  (cmd_depth),
      .resp_depth (resp_depth)
   ) dut0 (
      .clk         (clk),
      .rst         (rst),
      .cmd_valid   (cmd_valid),
      .cmd         (cmd),
      .cmd_credit  (cmd_credit),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .resp_credit (resp_credit)
   );

   always #4 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;  // rising edges so far.

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("ERROR at cycle %0d: %s", cyc, what);
   endtask

   initial begin
      int      sent;
      int      received;
      int      cmd_credits;
      int      dut_credits;
      int      credit_pulses;
      int      base;
      bit      idle;
      expect_t exp_item;

      clk         = 1'b0;
      rst         = 1'b1;
      cmd_valid   = 1'b0;
      cmd         = '0;
      resp_credit = 1'b0;
      errors      = 0;
      checks      = 0;
      lcg_state   = 32'hcfce_fb7d;

      for (int i = 0; i < max_lines * fields; i++) begin
         stim[i] = 32'hffff_ffff;
      end
      $readmemh("verif/mem_stimulus.txt", stim);
      n_lines = 0;
      while (n_lines < max_lines && stim[n_lines * fields] != 32'hffff_ffff) begin
         n_lines++;
      end
      if (n_lines == 0) begin
         report_failure("stimulus file is missing or holds no commands");
      end
      loaded = 1'b1;

      repeat (2) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      sent          = 0;
      received      = 0;
      cmd_credits   = cmd_depth;
      dut_credits   = resp_depth;
      credit_pulses = 0;

      while (received < n_lines) begin
         @(negedge clk);
         // outputs settled after the last rising edge.
         if (cmd_credit) begin
            credit_pulses++;
            cmd_credits++;
            if (cmd_credits > cmd_depth) begin
               report_failure("cmd_credit returned more credits than the command FIFO holds");
            end
            if (credit_pulses > sent) begin
               report_failure("cmd_credit pulsed more often than commands were sent");
            end
         end
         if (resp_valid) begin
            if (dut_credits == 0) begin
               report_failure("resp_valid raised while the DUT held no response credit");
            end else begin
               dut_credits--;
            end
            if (scoreboard.size() == 0) begin
               report_failure("unexpected response with no command outstanding");
            end else begin
               exp_item = scoreboard.pop_front();
               if (resp.tag != exp_item.tag) begin
                  report_failure($sformatf("response tag %h came out of order, expected tag %h",
                                           resp.tag, exp_item.tag));
               end
               check_value("resp.status", 32'(resp.status), 32'(exp_item.status));
               check_value("resp.rdata", resp.rdata, exp_item.rdata);
               if (exp_item.timed) begin
                  check_value("resp latency", 32'(cyc) - exp_item.accept_cyc, 32'd3);
               end
               received++;
            end
         end

         // random back-pressure on the response channel.
         lcg_state   = lcg_next(lcg_state);
         resp_credit = 1'b0;
         if (dut_credits < resp_depth && lcg_state[31:28] < 4'd6) begin
            resp_credit = 1'b1;
            dut_credits++;
         end

         cmd_valid = 1'b0;
         idle      = (scoreboard.size() == 0) && (dut_credits > 0);
         if (sent < n_lines && cmd_credits > 0 && (sent >= iso_lines || idle)) begin
            base = sent * fields;
            cmd  = '{opcode: opcode_e'(stim[base][1:0]),
                     tag:    stim[base + 1][tag_w-1:0],
                     addr:   stim[base + 2][def_addr_w-1:0],
                     strb:   stim[base + 3][strb_w-1:0],
                     data:   stim[base + 4]};
            cmd_valid = 1'b1;
            cmd_credits--;
            exp_item = '{tag:        stim[base + 1][tag_w-1:0],
                         status:     status_e'(stim[base + 5][0]),
                         rdata:      stim[base + 6],
                         timed:      idle,
                         accept_cyc: 32'(cyc + 1)};
            scoreboard.push_back(exp_item);
            sent++;
         end
      end

      // nothing more may come back once every command is answered.
      resp_credit = 1'b0;
      repeat (8) begin
         @(negedge clk);
         if (cmd_credit) begin
            cmd_credits++;
         end
         if (resp_valid) begin
            report_failure("response arrived after the last expected one");
         end
      end
      check_value("host cmd credits", 32'(cmd_credits), 32'(cmd_depth));

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   initial begin
      wait (loaded);
      repeat ((n_lines + 2) * cycles_per_line) @(posedge clk);
      $display("watchdog: run did not finish within %0d cycles",
               (n_lines + 2) * cycles_per_line);
      $display("Done: errors found");
      $finish;
   end

endmodule

// ==== hw/mem_subsys_top.sv ====
module mem_subsys_top import mem_cfg_pkg::*; import mem_cmd_pkg::*; #(
   parameter int addr_w     = def_addr_w,
   parameter int cmd_depth  = 4,
   parameter int resp_depth = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      cmd_valid,
   input  cmd_word_t cmd,
   output logic      cmd_credit,
   output logic      resp_valid,
   output resp_t     resp,
   input  logic      resp_credit
);

   logic              op_valid;
   dec_op_t           op;
   logic              op_take;
   logic              slot_free;
   mem_req_t          mem_req;
   logic [data_w-1:0] rdata;
   logic              ready;
   logic              ctx_valid;
   logic [tag_w-1:0]  ctx_tag;
   logic              ctx_read;
   logic              ctx_err;

   cmd_decode #(.cmd_depth(cmd_depth)) decode0 (
      .clk        (clk),
      .rst        (rst),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_credit (cmd_credit),
      .op_valid   (op_valid),
      .op         (op),
      .op_take    (op_take)
   );

   cmd_execute execute0 (
      .clk       (clk),
      .rst       (rst),
      .op_valid  (op_valid),
      .op        (op),
      .op_take   (op_take),
      .slot_free (slot_free),
      .mem_req   (mem_req),
      .ctx_valid (ctx_valid),
      .ctx_tag   (ctx_tag),
      .ctx_read  (ctx_read),
      .ctx_err   (ctx_err)
   );

   ram #(.addr_w(addr_w)) ram0 (
      .clk   (clk),
      .rst   (rst),
      .req   (mem_req),
      .rdata (rdata),
      .ready (ready)
   );

   resp_return #(.resp_depth(resp_depth)) result0 (
      .clk         (clk),
      .rst         (rst),
      .ctx_valid   (ctx_valid),
      .ctx_tag     (ctx_tag),
      .ctx_read    (ctx_read),
      .ctx_err     (ctx_err),
      .ready       (ready),
      .rdata       (rdata),
      .slot_free   (slot_free),
      .resp_valid  (resp_valid),
      .resp        (resp),
      .resp_credit (resp_credit)
   );

endmodule

// ==== hw/resp_return.sv ====
module resp_return import mem_cfg_pkg::*; import mem_cmd_pkg::*; #(
   parameter int resp_depth = 4
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              ctx_valid,
   input  logic [tag_w-1:0]  ctx_tag,
   input  logic              ctx_read,
   input  logic              ctx_err,
   input  logic              ready,
   input  logic [data_w-1:0] rdata,
   output logic              slot_free,
   output logic              resp_valid,
   output resp_t             resp,
   input  logic              resp_credit
);

   localparam int ptr_w = (resp_depth > 1) ? $clog2(resp_depth) : 1;
   localparam int cnt_w = $clog2(resp_depth + 1);
   localparam int use_w = $clog2(resp_depth + 3);

   resp_t            fifo [resp_depth];
   resp_t            entry;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic [cnt_w-1:0] credit_cnt;
   logic [use_w-1:0] in_use;
   logic             pend_valid;
   logic [tag_w-1:0] pend_tag;
   logic             pend_read;
   logic             pend_err;
   logic             push;
   logic             pop;

   // error ops have no RAM reply to wait for.
   assign push = pend_valid & (pend_err | ready);
   assign pop  = resp_valid;

   assign entry = '{tag:    pend_tag,
                    status: pend_err ? st_err : st_ok,
                    rdata:  pend_read ? rdata : '0};

   assign in_use    = use_w'(count) + use_w'(ctx_valid) + use_w'(pend_valid);
   assign slot_free = (in_use < use_w'(resp_depth));

   assign resp_valid = (count != '0) & (credit_cnt != '0);
   assign resp       = fifo[rd_ptr];

   always_ff @(posedge clk) begin
      if (ctx_valid) begin
         pend_tag  <= ctx_tag;
         pend_read <= ctx_read;
         pend_err  <= ctx_err;
      end
      if (push) begin
         fifo[wr_ptr] <= entry;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pend_valid <= 1'b0;
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         credit_cnt <= cnt_w'(resp_depth);  // host starts with room for all.
      end else begin
         pend_valid <= ctx_valid;
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(resp_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(resp_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         case ({resp_credit, pop})
            2'b10:   credit_cnt <= credit_cnt + 1'b1;
            2'b01:   credit_cnt <= credit_cnt - 1'b1;
            default: credit_cnt <= credit_cnt;
         endcase
      end
   end

   a_credit_bound: assert property (@(posedge clk) disable iff (rst)
      credit_cnt <= cnt_w'(resp_depth))
      else $error("resp_return: host returned more credits than it was given");

endmodule

// ==== hw/cmd_execute.sv ====
module cmd_execute import mem_cfg_pkg::*; import mem_cmd_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             op_valid,
   input  dec_op_t          op,
   output logic             op_take,
   input  logic             slot_free,
   output mem_req_t         mem_req,
   output logic             ctx_valid,
   output logic [tag_w-1:0] ctx_tag,
   output logic             ctx_read,
   output logic             ctx_err
);

   logic                  en_q;
   logic [def_addr_w-1:0] addr_q;
   logic [strb_w-1:0]     strb_q;
   logic [data_w-1:0]     wdata_q;

   // the result stage must have room before an op leaves.
   assign op_take = op_valid & slot_free;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         en_q      <= 1'b0;
         ctx_valid <= 1'b0;
      end else begin
         en_q      <= op_take & ~op.is_err;  // error ops skip the RAM.
         ctx_valid <= op_take;
      end
   end

   always_ff @(posedge clk) begin
      if (op_take) begin
         addr_q   <= op.addr;
         strb_q   <= op.is_write ? op.strb : '0;  // reads never write.
         wdata_q  <= op.data;
         ctx_tag  <= op.tag;
         ctx_read <= op.is_read;
         ctx_err  <= op.is_err;
      end
   end

   assign mem_req = '{en: en_q, addr: addr_q, strb: strb_q, wdata: wdata_q};

   a_op_one_kind: assert property (@(posedge clk) disable iff (rst)
      op_valid |-> $onehot({op.is_read, op.is_write, op.is_err}))
      else $error("cmd_execute: offered op is not exactly one of read, write or error");

endmodule

// ==== hw/cmd_decode.sv ====
module cmd_decode import mem_cmd_pkg::*; #(
   parameter int cmd_depth = 4
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      cmd_valid,
   input  cmd_word_t cmd,
   output logic      cmd_credit,
   output logic      op_valid,
   output dec_op_t   op,
   input  logic      op_take
);

   localparam int ptr_w = (cmd_depth > 1) ? $clog2(cmd_depth) : 1;
   localparam int cnt_w = $clog2(cmd_depth + 1);

   cmd_word_t        fifo [cmd_depth];
   cmd_word_t        head;
   logic [ptr_w-1:0] wr_ptr;
   logic [ptr_w-1:0] rd_ptr;
   logic [cnt_w-1:0] count;
   logic             push;
   logic             pop;

   assign push     = cmd_valid;
   assign pop      = op_take & op_valid;
   assign op_valid = (count != '0);
   assign head     = fifo[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         fifo[wr_ptr] <= cmd;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         cmd_credit <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == ptr_w'(cmd_depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == ptr_w'(cmd_depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         cmd_credit <= pop;  // each freed slot goes back to the host.
      end
   end

   always_comb begin
      op          = '0;
      op.tag      = head.tag;
      op.addr     = head.addr;
      op.strb     = head.strb;
      op.data     = head.data;
      case (head.opcode)
         op_read:            op.is_read  = 1'b1;
         op_write:           op.is_write = 1'b1;
         op_rsvd2, op_rsvd3: op.is_err   = 1'b1;
         default:            op.is_err   = 1'b1;
      endcase
   end

   a_no_overrun: assert property (@(posedge clk) disable iff (rst)
      cmd_valid |-> (count != cnt_w'(cmd_depth)))
      else $error("cmd_decode: command sent with no credit left");

endmodule

// ==== hw/ram.sv ====
module ram import mem_cfg_pkg::*; #(
   parameter int addr_w = def_addr_w
) (
   input  logic              clk,
   input  logic              rst,
   input  mem_req_t          req,
   output logic [data_w-1:0] rdata,
   output logic              ready
);

   logic [addr_w-1:0] lane_addr;

   assign lane_addr = req.addr[addr_w-1:0];

   byte_mem #(.addr_w(addr_w)) byte_lane0 (
      .clk      (clk),
      .en       (req.en),
      .we       (req.strb[0]),
      .addr     (lane_addr),
      .data_in  (req.wdata[7:0]),
      .data_out (rdata[7:0])
   );

   byte_mem #(.addr_w(addr_w)) byte_lane1 (
      .clk      (clk),
      .en       (req.en),
      .we       (req.strb[1]),
      .addr     (lane_addr),
      .data_in  (req.wdata[15:8]),
      .data_out (rdata[15:8])
   );

   byte_mem #(.addr_w(addr_w)) byte_lane2 (
      .clk      (clk),
      .en       (req.en),
      .we       (req.strb[2]),
      .addr     (lane_addr),
      .data_in  (req.wdata[23:16]),
      .data_out (rdata[23:16])
   );

   byte_mem #(.addr_w(addr_w)) byte_lane3 (
      .clk      (clk),
      .en       (req.en),
      .we       (req.strb[3]),
      .addr     (lane_addr),
      .data_in  (req.wdata[31:24]),
      .data_out (rdata[31:24])
   );

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready <= 1'b0;
      end else begin
         ready <= req.en;  // one cycle access.
      end
   end

   a_req_known: assert property (@(posedge clk) disable iff (rst)
      req.en |-> !$isunknown({req.addr, req.strb}))
      else $error("ram: enabled request with an unknown address or strobe");

endmodule

// ==== hw/byte_mem.sv ====
module byte_mem #(
   parameter int addr_w = 10
) (
   input  logic              clk,
   input  logic              en,
   input  logic              we,
   input  logic [addr_w-1:0] addr,
   input  logic [7:0]        data_in,
   output logic [7:0]        data_out
);

   logic [7:0] mem [2**addr_w];

   // read-first, data_out shows the old byte on a write.
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= data_in;
         end
         data_out <= mem[addr];
      end
   end

endmodule

// ==== hw/mem_cmd_pkg.sv ====
package mem_cmd_pkg;

   import mem_cfg_pkg::*;

   localparam int tag_w = 4;

   typedef enum logic [1:0] {
      op_read  = 2'd0,
      op_write = 2'd1,
      op_rsvd2 = 2'd2,
      op_rsvd3 = 2'd3
   } opcode_e;

   typedef enum logic {
      st_ok  = 1'b0,
      st_err = 1'b1
   } status_e;

   // host command word, 52 bits.
   typedef struct packed {
      opcode_e               opcode;
      logic [tag_w-1:0]      tag;
      logic [def_addr_w-1:0] addr;
      logic [strb_w-1:0]     strb;
      logic [data_w-1:0]     data;
   } cmd_word_t;

   typedef struct packed {
      logic                  is_read;
      logic                  is_write;
      logic                  is_err;
      logic [tag_w-1:0]      tag;
      logic [def_addr_w-1:0] addr;
      logic [strb_w-1:0]     strb;
      logic [data_w-1:0]     data;
   } dec_op_t;

   typedef struct packed {
      logic [tag_w-1:0]  tag;
      status_e           status;
      logic [data_w-1:0] rdata;
   } resp_t;

endpackage

// ==== hw/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

   localparam int data_w     = 32;
   localparam int strb_w     = data_w / 8;
   localparam int def_addr_w = 10;  // word address, 4 kB total.

   // native port between execute and the RAM.
   typedef struct packed {
      logic                  en;
      logic [def_addr_w-1:0] addr;
      logic [strb_w-1:0]     strb;
      logic [data_w-1:0]     wdata;
   } mem_req_t;

endpackage
